// File: include/lidar_cmd_params.svh
`ifndef LIDAR_CMD_PARAMS_SVH
`define LIDAR_CMD_PARAMS_SVH

// stream framing
`define WORD_W              32
`define HEAD_CODE           16'h1234
`define ENABLE_WORD         32'h1111_1111

// zone RAM geometry
`define ZONE_DEPTH          1024
`define ZONE_AW             10
`define ZONE_DW             18

// accepted motor speed range
`define MOTOR_SPEED_MIN     32'd8
`define MOTOR_SPEED_MAX     32'd15

// register values after reset
`define RST_LASER_FREQ      32'd1_000_000
`define RST_MOTOR_SPEED     8'd15
`define RST_ZERO_ANGLE      16'd135       // 135 x 0.333 deg past the index mark
`define RST_ZERO_DISTANCE   16'd0
`define RST_APD_VOLT        16'd548
`define RST_HW_TYPE         2'd1
`define RST_LASER_ENABLE    1'b1
`define RST_MOTOR_ENABLE    1'b1

`endif

// File: hdl/lidar_cmd_pkg.sv
`default_nettype none

`include "lidar_cmd_params.svh"

package lidar_cmd_pkg;

    // command codes in the low half of the head word
    typedef enum logic [15:0]
    {
        SET_HW_TYPE          = 16'h4006,
        LASER_ENABLE         = 16'ha100,
        LASER_FREQ           = 16'ha101,
        MOTOR_ENABLE         = 16'ha200,
        MOTOR_SPEED          = 16'ha201,
        ZERO_DISTANCE_REVISE = 16'ha301,
        ZERO_ANGLE_REVISE    = 16'ha302,
        APD_VOLT_SETTING     = 16'ha702,
        WR_ZONE              = 16'hb100
    } cmd_code_t;

    typedef enum logic [1:0]
    {
        IDLE,                           // hunting for head code
        LENGTH,
        PAYLOAD,
        CHECKSUM                        // one word, dropped
    } parse_state_t;

    typedef logic [`WORD_W-1:0]  word_t;
    typedef logic [15:0]         word_index_t;     // payload index and length
    typedef logic [`ZONE_AW-1:0] zone_addr_t;
    typedef logic [`ZONE_DW-1:0] zone_data_t;

endpackage

`default_nettype wire

// File: hdl/cmd_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cmd_wr_if;

    import lidar_cmd_pkg::*;

    logic        wr_valid;              // one cycle per payload word
    cmd_code_t   cmd;
    word_index_t index;                 // 0 for the first payload word
    word_t       data;

    modport source
    (
        output wr_valid,
        output cmd,
        output index,
        output data
    );

    modport sink
    (
        input  wr_valid,
        input  cmd,
        input  index,
        input  data
    );

endinterface

`default_nettype wire

// File: hdl/frame_parser.sv
`timescale 1ns/100ps
`default_nettype none

`include "lidar_cmd_params.svh"

module frame_parser
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 s_valid,
    input  wire lidar_cmd_pkg::word_t s_data,
    output logic                      s_ready,
    cmd_wr_if.source                  wr
);

    import lidar_cmd_pkg::*;

    parse_state_t state;
    word_index_t  data_len;
    word_index_t  word_cnt;
    logic         accept;
    logic         head_hit;
    logic         last_word;
    logic         empty_frame;

    assign accept      = s_valid & s_ready;
    assign head_hit    = (s_data[31:16] == `HEAD_CODE);
    assign last_word   = (word_cnt == data_len - 16'd1);
    assign empty_frame = (s_data[15:0] == 16'd0);

    // no back-pressure, ready comes up one cycle after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s_ready <= 1'b0;
        else
            s_ready <= 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            data_len <= '0;
            word_cnt <= '0;
            wr.cmd   <= cmd_code_t'(16'h0000);
        end
        else if (accept)
        begin
            case (state)
                IDLE:
                begin
                    if (head_hit)
                    begin
                        wr.cmd <= cmd_code_t'(s_data[15:0]);
                        state  <= LENGTH;
                    end
                end
                LENGTH:
                begin
                    data_len <= s_data[15:0];
                    word_cnt <= '0;
                    if (empty_frame)
                        state <= CHECKSUM;      // no payload, go straight to checksum
                    else
                        state <= PAYLOAD;
                end
                PAYLOAD:
                begin
                    word_cnt <= word_cnt + 16'd1;
                    if (last_word)
                        state <= CHECKSUM;
                end
                CHECKSUM:
                begin
                    state <= IDLE;              // not verified
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wr.wr_valid <= 1'b0;
        else
            wr.wr_valid <= accept && (state == PAYLOAD);
    end

    // payload word and its number, valid with wr_valid
    always_ff @(posedge clk)
    begin
        if (accept && (state == PAYLOAD))
        begin
            wr.data  <= s_data;
            wr.index <= word_cnt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/zone_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "lidar_cmd_params.svh"

module zone_ram
#(
    parameter int DEPTH  = `ZONE_DEPTH,
    parameter int DATA_W = `ZONE_DW
)
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    cmd_wr_if.sink                         wr,
    input  wire logic                      zone_rden,
    input  wire lidar_cmd_pkg::zone_addr_t zone_rdaddr,
    output lidar_cmd_pkg::zone_data_t      zone_rddata
);

    import lidar_cmd_pkg::*;

    localparam int          AW      = $clog2(DEPTH);
    localparam int unsigned DEPTH_U = DEPTH;

    logic [DATA_W-1:0] mem [DEPTH];
    logic              wr_en;
    logic [AW-1:0]     wr_addr;

    // words past the end of the RAM are dropped
    assign wr_en   = wr.wr_valid && (wr.cmd == WR_ZONE) && (32'(wr.index) < DEPTH_U);
    assign wr_addr = wr.index[AW-1:0];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr.data[DATA_W-1:0];
    end

    // registered read, holds between reads
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            zone_rddata <= '0;
        else if (zone_rden)
            zone_rddata <= mem[zone_rdaddr];
    end

endmodule

`default_nettype wire

// File: hdl/param_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "lidar_cmd_params.svh"

module param_bank
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    cmd_wr_if.sink               wr,
    output logic                 laser_enable,
    output lidar_cmd_pkg::word_t laser_freq,
    output logic                 motor_enable,
    output logic [7:0]           motor_speed,
    output logic [15:0]          zero_distance_revise,
    output logic [15:0]          zero_angle_revise,
    output logic [15:0]          apd_volt_setting,
    output logic                 dac_set_flag,
    output logic [1:0]           hw_type
);

    import lidar_cmd_pkg::*;

    logic enable_hit;
    logic speed_ok;

    assign enable_hit = (wr.data == `ENABLE_WORD);     // anything else disables
    assign speed_ok   = (wr.data >= `MOTOR_SPEED_MIN) && (wr.data <= `MOTOR_SPEED_MAX);

    // last payload word of a frame wins
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            laser_enable         <= `RST_LASER_ENABLE;
            laser_freq           <= `RST_LASER_FREQ;
            motor_enable         <= `RST_MOTOR_ENABLE;
            motor_speed          <= `RST_MOTOR_SPEED;
            zero_distance_revise <= `RST_ZERO_DISTANCE;
            zero_angle_revise    <= `RST_ZERO_ANGLE;
            apd_volt_setting     <= `RST_APD_VOLT;
            hw_type              <= `RST_HW_TYPE;
        end
        else if (wr.wr_valid)
        begin
            case (wr.cmd)
                LASER_ENABLE:
                begin
                    laser_enable <= enable_hit;
                end
                LASER_FREQ:
                begin
                    laser_freq <= wr.data;
                end
                MOTOR_ENABLE:
                begin
                    motor_enable <= enable_hit;
                end
                MOTOR_SPEED:
                begin
                    if (speed_ok)
                        motor_speed <= wr.data[7:0];     // out of range is ignored
                end
                ZERO_DISTANCE_REVISE:
                begin
                    zero_distance_revise <= wr.data[15:0];
                end
                ZERO_ANGLE_REVISE:
                begin
                    zero_angle_revise <= wr.data[15:0];
                end
                APD_VOLT_SETTING:
                begin
                    apd_volt_setting <= wr.data[15:0];
                end
                SET_HW_TYPE:
                begin
                    hw_type <= wr.data[1:0];
                end
                default:
                begin
                    // zone words and unknown commands
                end
            endcase
        end
    end

    // DAC reload pulse, one per APD word written
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            dac_set_flag <= 1'b0;
        else
            dac_set_flag <= wr.wr_valid && (wr.cmd == APD_VOLT_SETTING);
    end

endmodule

`default_nettype wire

// File: hdl/lidar_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none

module lidar_cmd_top
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire logic                      s_valid,
    input  wire lidar_cmd_pkg::word_t      s_data,
    output logic                           s_ready,

    input  wire logic                      zone_rden,
    input  wire lidar_cmd_pkg::zone_addr_t zone_rdaddr,
    output lidar_cmd_pkg::zone_data_t      zone_rddata,

    output logic                           laser_enable,
    output lidar_cmd_pkg::word_t           laser_freq,
    output logic                           motor_enable,
    output logic [7:0]                     motor_speed,
    output logic [15:0]                    zero_distance_revise,
    output logic [15:0]                    zero_angle_revise,
    output logic [15:0]                    apd_volt_setting,
    output logic                           dac_set_flag,
    output logic [1:0]                     hw_type
);

    cmd_wr_if wr_bus ();                // parser to both sinks

    frame_parser i_parser
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_data  (s_data),
        .s_ready (s_ready),
        .wr      (wr_bus)
    );

    zone_ram i_zone_ram
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr_bus),
        .zone_rden   (zone_rden),
        .zone_rdaddr (zone_rdaddr),
        .zone_rddata (zone_rddata)
    );

    param_bank i_param_bank
    (
        .clk                  (clk),
        .rst_n                (rst_n),
        .wr                   (wr_bus),
        .laser_enable         (laser_enable),
        .laser_freq           (laser_freq),
        .motor_enable         (motor_enable),
        .motor_speed          (motor_speed),
        .zero_distance_revise (zero_distance_revise),
        .zero_angle_revise    (zero_angle_revise),
        .apd_volt_setting     (apd_volt_setting),
        .dac_set_flag         (dac_set_flag),
        .hw_type              (hw_type)
    );

endmodule

`default_nettype wire

// File: sim/tb_lidar_cmd.sv
`timescale 1ns/100ps
`default_nettype none

`include "lidar_cmd_params.svh"

module tb_lidar_cmd;

    import lidar_cmd_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        s_valid;
    word_t       s_data;
    logic        s_ready;
    logic        zone_rden;
    zone_addr_t  zone_rdaddr;
    zone_data_t  zone_rddata;
    logic        laser_enable;
    word_t       laser_freq;
    logic        motor_enable;
    logic [7:0]  motor_speed;
    logic [15:0] zero_distance_revise;
    logic [15:0] zero_angle_revise;
    logic [15:0] apd_volt_setting;
    logic        dac_set_flag;
    logic [1:0]  hw_type;

    logic        exp_laser_enable;              // reference model
    word_t       exp_laser_freq;
    logic        exp_motor_enable;
    logic [7:0]  exp_motor_speed;
    logic [15:0] exp_zero_distance;
    logic [15:0] exp_zero_angle;
    logic [15:0] exp_apd_volt;
    logic [1:0]  exp_hw_type;
    int          exp_dac_cnt;
    zone_data_t  exp_zone [`ZONE_DEPTH];

    word_t       pay [64];                      // payload of the next frame
    int          words_sent;
    int          dac_seen;
    int          errors;
    int          checks;
    event        frame_done;
    event        check_done;

    lidar_cmd_top i_dut
    (
        .clk                  (clk),
        .rst_n                (rst_n),
        .s_valid              (s_valid),
        .s_data               (s_data),
        .s_ready              (s_ready),
        .zone_rden            (zone_rden),
        .zone_rdaddr          (zone_rdaddr),
        .zone_rddata          (zone_rddata),
        .laser_enable         (laser_enable),
        .laser_freq           (laser_freq),
        .motor_enable         (motor_enable),
        .motor_speed          (motor_speed),
        .zero_distance_revise (zero_distance_revise),
        .zero_angle_revise    (zero_angle_revise),
        .apd_volt_setting     (apd_volt_setting),
        .dac_set_flag         (dac_set_flag),
        .hw_type              (hw_type)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk)
    begin
        if (dac_set_flag)
            dac_seen++;                         // one per APD word expected
    end

    task automatic log_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    // expected register and RAM state after one frame
    function void apply_frame(input cmd_code_t cmd, input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            case (cmd)
                LASER_ENABLE:         exp_laser_enable = (pay[i] == `ENABLE_WORD);
                LASER_FREQ:           exp_laser_freq = pay[i];
                MOTOR_ENABLE:         exp_motor_enable = (pay[i] == `ENABLE_WORD);
                MOTOR_SPEED:
                begin
                    if (pay[i] >= `MOTOR_SPEED_MIN && pay[i] <= `MOTOR_SPEED_MAX)
                        exp_motor_speed = pay[i][7:0];
                end
                ZERO_DISTANCE_REVISE: exp_zero_distance = pay[i][15:0];
                ZERO_ANGLE_REVISE:    exp_zero_angle = pay[i][15:0];
                APD_VOLT_SETTING:
                begin
                    exp_apd_volt = pay[i][15:0];
                    exp_dac_cnt++;
                end
                SET_HW_TYPE:          exp_hw_type = pay[i][1:0];
                WR_ZONE:
                begin
                    if (i < `ZONE_DEPTH)
                        exp_zone[i] = pay[i][`ZONE_DW-1:0];
                end
                default:              ;
            endcase
        end
    endfunction

    task automatic compare_outputs();
        checks++;
        if (s_ready !== 1'b1)
            log_mismatch("s_ready not high");
        if (laser_enable !== exp_laser_enable)
            log_mismatch($sformatf("laser_enable %0b, expected %0b",
                                   laser_enable, exp_laser_enable));
        if (laser_freq !== exp_laser_freq)
            log_mismatch($sformatf("laser_freq %0h, expected %0h",
                                   laser_freq, exp_laser_freq));
        if (motor_enable !== exp_motor_enable)
            log_mismatch($sformatf("motor_enable %0b, expected %0b",
                                   motor_enable, exp_motor_enable));
        if (motor_speed !== exp_motor_speed)
            log_mismatch($sformatf("motor_speed %0d, expected %0d",
                                   motor_speed, exp_motor_speed));
        if (zero_distance_revise !== exp_zero_distance)
            log_mismatch($sformatf("zero_distance_revise %0h, expected %0h",
                                   zero_distance_revise, exp_zero_distance));
        if (zero_angle_revise !== exp_zero_angle)
            log_mismatch($sformatf("zero_angle_revise %0h, expected %0h",
                                   zero_angle_revise, exp_zero_angle));
        if (apd_volt_setting !== exp_apd_volt)
            log_mismatch($sformatf("apd_volt_setting %0h, expected %0h",
                                   apd_volt_setting, exp_apd_volt));
        if (hw_type !== exp_hw_type)
            log_mismatch($sformatf("hw_type %0d, expected %0d", hw_type, exp_hw_type));
        if (dac_seen != exp_dac_cnt)
            log_mismatch($sformatf("dac_set_flag high %0d cycles, expected %0d",
                                   dac_seen, exp_dac_cnt));
    endtask

    initial
    begin
        forever
        begin
            @(frame_done);
            repeat (3) @(negedge clk);
            compare_outputs();
            -> check_done;
        end
    end

    // starts and ends just after a falling edge
    task automatic send_word(input word_t w);
        int gap;
        gap = $urandom_range(0, 1);
        repeat (gap)
        begin
            s_valid = 1'b0;
            @(negedge clk);
        end
        s_valid = 1'b1;
        s_data  = w;
        while (!s_ready)
            @(negedge clk);
        @(negedge clk);                         // taken at the rising edge in between
        words_sent++;
    endtask

    task automatic send_frame(input cmd_code_t cmd, input int n);
        int i;
        send_word({`HEAD_CODE, cmd});
        send_word(word_t'(n));
        for (i = 0; i < n; i++)
            send_word(pay[i]);
        send_word($urandom());                  // checksum
        s_valid = 1'b0;
        apply_frame(cmd, n);
        -> frame_done;
        @(check_done);
    endtask

    task automatic send_single(input cmd_code_t cmd, input word_t value);
        pay[0] = value;
        send_frame(cmd, 1);
    endtask

    task automatic read_zone(input int addr);
        zone_rden   = 1'b1;
        zone_rdaddr = addr[`ZONE_AW-1:0];
        @(negedge clk);
        zone_rden = 1'b0;
        checks++;
        if (zone_rddata !== exp_zone[addr])
            log_mismatch($sformatf("zone[%0d] read %0h, expected %0h",
                                   addr, zone_rddata, exp_zone[addr]));
    endtask

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < words_sent * 4 + 200)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog: run timed out after %0d clock cycles", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin : main_seq
        int i;
        void'($urandom(95593));
        rst_n       = 1'b0;
        s_valid     = 1'b0;
        s_data      = '0;
        zone_rden   = 1'b0;
        zone_rdaddr = '0;
        words_sent  = 0;
        dac_seen    = 0;
        errors      = 0;
        checks      = 0;
        exp_laser_enable  = `RST_LASER_ENABLE;
        exp_laser_freq    = `RST_LASER_FREQ;
        exp_motor_enable  = `RST_MOTOR_ENABLE;
        exp_motor_speed   = `RST_MOTOR_SPEED;
        exp_zero_distance = `RST_ZERO_DISTANCE;
        exp_zero_angle    = `RST_ZERO_ANGLE;
        exp_apd_volt      = `RST_APD_VOLT;
        exp_hw_type       = `RST_HW_TYPE;
        exp_dac_cnt       = 0;
        @(negedge clk);
        checks++;
        if (s_ready !== 1'b0)
            log_mismatch("s_ready high during reset");
        @(negedge clk);
        rst_n = 1'b1;
        while (!s_ready)
            @(negedge clk);
        -> frame_done;                          // defaults after reset
        @(check_done);
        send_single(LASER_FREQ, 32'd2_500_000);
        send_single(ZERO_DISTANCE_REVISE, $urandom());
        send_single(ZERO_ANGLE_REVISE, 32'h0000_0107);
        send_single(SET_HW_TYPE, 32'h0000_0006);
        send_single(LASER_ENABLE, 32'h0000_0001);
        send_single(LASER_ENABLE, `ENABLE_WORD);
        send_single(MOTOR_ENABLE, 32'h1111_1110);
        send_single(MOTOR_ENABLE, `ENABLE_WORD);
        for (i = 0; i < 3; i++)
            pay[i] = $urandom();
        send_frame(LASER_FREQ, 3);              // last word should stick
        send_single(MOTOR_SPEED, 32'd7);
        send_single(MOTOR_SPEED, 32'd8);
        send_single(MOTOR_SPEED, 32'd16);
        send_single(MOTOR_SPEED, 32'd15);
        for (i = 0; i < 3; i++)
            pay[i] = $urandom();
        send_frame(APD_VOLT_SETTING, 3);
        for (i = 0; i < 16; i++)
            pay[i] = $urandom();
        send_frame(WR_ZONE, 16);
        for (i = 0; i < 16; i++)
            read_zone(i);
        send_word(32'hdead_beef);               // no head code
        send_word(32'h0000_a101);
        send_word(32'h1233_ffff);
        s_valid = 1'b0;
        send_single(ZERO_ANGLE_REVISE, $urandom());
        send_frame(LASER_FREQ, 0);
        send_frame(APD_VOLT_SETTING, 0);
        for (i = 0; i < 5; i++)
            pay[i] = $urandom();
        send_frame(WR_ZONE, 5);
        for (i = 0; i < 16; i++)
            read_zone(i);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: lidar_cmd.f
+incdir+include
hdl/lidar_cmd_pkg.sv
hdl/cmd_wr_if.sv
hdl/frame_parser.sv
hdl/zone_ram.sv
hdl/param_bank.sv
hdl/lidar_cmd_top.sv
sim/tb_lidar_cmd.sv

// File: Makefile
TOP = tb_lidar_cmd

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f lidar_cmd.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
